//--- vlog.f
source/wb_pkg.sv
source/frame_stats.sv
source/recip_lut.sv
source/channel_gain.sv
source/sync_delay.sv
source/white_balance.sv
sim/white_balance_sva.sv
sim/white_balance_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the white balance testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module white_balance_tb -f vlog.f \
    > sim.log 2>&1 \
    && ./obj_dir/Vwhite_balance_tb +verilator+error+limit+1000 >> sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log
if grep -q "TESTS FAILED" sim.log; then
    echo "simulation failed, see sim.log" && exit 1
fi
grep -q "TESTS PASSED" sim.log && echo "simulation passed" || { echo "no result, see sim.log"; exit 1; }

//--- sim/white_balance_tb.sv
`timescale 1ns/1ps

module white_balance_tb import wb_pkg::*; ();

    localparam int H_ACT         = 8;
    localparam int V_ACT         = 4;
    localparam int X_W           = $clog2(H_ACT);
    localparam int Y_W           = $clog2(V_ACT);
    localparam int AVG_SHIFT     = $clog2(H_ACT * V_ACT); // 32 pixels give an exact average
    localparam int DRAIN_TIMEOUT = 20;

    logic             clk;
    logic             i_rst;
    logic             i_vsync;
    logic             i_hsync;
    logic             i_de;
    logic [PIX_W-1:0] i_r;
    logic [PIX_W-1:0] i_g;
    logic [PIX_W-1:0] i_b;
    logic [X_W-1:0]   i_x;
    logic [Y_W-1:0]   i_y;
    logic             o_vsync;
    logic             o_hsync;
    logic             o_de;
    logic [PIX_W-1:0] o_r;
    logic [PIX_W-1:0] o_g;
    logic [PIX_W-1:0] o_b;
    logic [X_W-1:0]   o_x;
    logic [Y_W-1:0]   o_y;

    logic [31:0]        lcg_state    = 32'd59;
    logic [3*PIX_W-1:0] exp_q[$];             // {r, g, b} still in the pipeline
    string              test_name    = "reset";
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 sum_r        = 0;
    int                 sum_g        = 0;
    int                 sum_b        = 0;
    int                 avg_r        = 0;
    int                 avg_g        = 0;
    int                 avg_b        = 0;
    int                 k_ref        = 0;

    white_balance #(.H_ACT(H_ACT), .V_ACT(V_ACT)) i_white_balance (
        .clk(clk), .i_rst(i_rst), .i_vsync(i_vsync), .i_hsync(i_hsync), .i_de(i_de),
        .i_r(i_r), .i_g(i_g), .i_b(i_b), .i_x(i_x), .i_y(i_y),
        .o_vsync(o_vsync), .o_hsync(o_hsync), .o_de(o_de),
        .o_r(o_r), .o_g(o_g), .o_b(o_b), .o_x(o_x), .o_y(o_y)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [PIX_W-1:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // pixel * k * floor(2^32 / avg) with the upper bits kept and clamped at 255
    function automatic logic [PIX_W-1:0] gain_ref(input int pix, input int k, input int avg);
        longint unsigned recip;
        longint unsigned scaled;
        if (avg < 2) begin
            recip = 64'hFFFF_FFFF;
        end else begin
            recip = (64'd1 << 32) / 64'(avg);
        end
        scaled = (64'(pix) * 64'(k) * recip) >> 32;
        if (scaled >= 64'd255) begin
            return 8'hFF;
        end
        return PIX_W'(scaled);
    endfunction

    task automatic drive(input logic v, input logic h, input logic de, input logic [PIX_W-1:0] r,
                         input logic [PIX_W-1:0] g, input logic [PIX_W-1:0] b,
                         input int x, input int y);
        @(posedge clk);
        i_vsync <= v;
        i_hsync <= h;
        i_de    <= de;
        i_r     <= r;
        i_g     <= g;
        i_b     <= b;
        i_x     <= X_W'(x);
        i_y     <= Y_W'(y);
        if (de) begin
            sum_r += int'(r);
            sum_g += int'(g);
            sum_b += int'(b);
            exp_q.push_back({gain_ref(int'(r), k_ref, avg_r), gain_ref(int'(g), k_ref, avg_g),
                             gain_ref(int'(b), k_ref, avg_b)});
        end
    endtask

    task automatic blank(input int cycles, input logic v, input logic h);
        repeat (cycles) drive(v, h, 1'b0, '0, '0, '0, 0, 0);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d pixels of %s never left the DUT", exp_q.size(), test_name);
            other_errors++;
            exp_q.delete();
        end
    endtask

    task automatic run_frame(input string name, input bit rnd, input logic [PIX_W-1:0] cr,
                             input logic [PIX_W-1:0] cg, input logic [PIX_W-1:0] cb);
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
        avg_r     = sum_r >> AVG_SHIFT; // vsync rise freezes the last frame
        avg_g     = sum_g >> AVG_SHIFT;
        avg_b     = sum_b >> AVG_SHIFT;
        k_ref     = (avg_r + avg_g + avg_b) / 3;
        sum_r     = 0;
        sum_g     = 0;
        sum_b     = 0;
        test_name = name;
        blank(2, 1'b1, 1'b0);
        blank(4, 1'b0, 1'b0);
        for (int y = 0; y < V_ACT; y++) begin
            blank(2, 1'b0, 1'b1);
            blank(1, 1'b0, 1'b0);
            for (int x = 0; x < H_ACT; x++) begin
                r = rnd ? rand_byte() : cr;
                g = rnd ? rand_byte() : cg;
                b = rnd ? rand_byte() : cb;
                drive(1'b0, 1'b0, 1'b1, r, g, b, x, y); // back to back within the line
            end
        end
        blank(1, 1'b0, 1'b0);
        wait_drain();
    endtask

    task automatic check_channel(input string ch, input logic [PIX_W-1:0] want,
                                 input logic [PIX_W-1:0] got);
        assert (got == want) else begin
            $display("[FAIL] %s %s expected %0d actual %0d", test_name, ch, want, got);
            value_errors++;
        end
    endtask

    always @(negedge clk) begin
        logic [3*PIX_W-1:0] want;
        if (!i_rst && o_de) begin
            if (exp_q.size() == 0) begin
                $display("the DUT put out a pixel at %0t when none was pending", $time);
                other_errors++;
            end else begin
                want = exp_q.pop_front();
                check_channel("r", want[3*PIX_W-1:2*PIX_W], o_r);
                check_channel("g", want[2*PIX_W-1:PIX_W], o_g);
                check_channel("b", want[PIX_W-1:0], o_b);
            end
        end
    end

    initial begin
        i_rst   <= 1'b1;
        i_vsync <= 1'b1; // timing levels held high through reset
        i_hsync <= 1'b1;
        i_de    <= 1'b1;
        i_r     <= '0;
        i_g     <= '0;
        i_b     <= '0;
        i_x     <= '0;
        i_y     <= '0;
        repeat (16) @(posedge clk);
        i_rst   <= 1'b0;
        i_vsync <= 1'b0;
        i_hsync <= 1'b0;
        i_de    <= 1'b0;
        run_frame("first_frame", 1'b0, 8'd200, 8'd100, 8'd50); // k still 0
        run_frame("cast_gain", 1'b0, 8'd200, 8'd100, 8'd50);
        run_frame("cast_gain", 1'b0, 8'd200, 8'd100, 8'd10);
        run_frame("saturation", 1'b0, 8'd250, 8'd250, 8'd250);
        run_frame("zero_avg", 1'b0, 8'd120, 8'd0, 8'd90);
        run_frame("zero_avg", 1'b0, 8'd60, 8'd30, 8'd60);
        for (int f = 0; f < 4; f++) begin
            run_frame("random", 1'b1, '0, '0, '0);
        end
        blank(4, 1'b0, 1'b0);
        $display("errors: value %0d, other %0d, assertion %0d", value_errors, other_errors,
                 i_white_balance.i_sva.sva_errors);
        if (value_errors + other_errors + i_white_balance.i_sva.sva_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : white_balance_tb

//--- sim/white_balance_sva.sv
`timescale 1ns/1ps

module white_balance_sva import wb_pkg::*; #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input logic                     clk,
    input logic                     i_rst,
    input logic                     i_vsync,
    input logic                     i_hsync,
    input logic                     i_de,
    input logic [$clog2(H_ACT)-1:0] i_x,
    input logic [$clog2(V_ACT)-1:0] i_y,
    input logic                     o_vsync,
    input logic                     o_hsync,
    input logic                     o_de,
    input logic [$clog2(H_ACT)-1:0] o_x,
    input logic [$clog2(V_ACT)-1:0] o_y
);

    int         sva_errors = 0;
    logic [1:0] since_rst;  // cycles since reset, stops at the latency

    always_ff @(posedge clk) begin
        if (i_rst) begin
            since_rst <= '0;
        end else if (since_rst != 2'(WB_LATENCY)) begin
            since_rst <= since_rst + 2'd1;
        end
    end

    a_sync_lag: assert property (@(posedge clk) disable iff (i_rst)
        (since_rst == 2'(WB_LATENCY)) |-> (o_vsync == $past(i_vsync, WB_LATENCY)) &&
            (o_hsync == $past(i_hsync, WB_LATENCY)) && (o_de == $past(i_de, WB_LATENCY)))
        else begin
            $error("sync or de output differs from its input 3 cycles earlier");
            sva_errors++;
        end

    a_coord_lag: assert property (@(posedge clk) disable iff (i_rst)
        (since_rst == 2'(WB_LATENCY)) |->
            (o_x == $past(i_x, WB_LATENCY)) && (o_y == $past(i_y, WB_LATENCY)))
        else begin
            $error("coordinate output differs from its input 3 cycles earlier");
            sva_errors++;
        end

    a_reset_clears: assert property (@(posedge clk)
        $past(i_rst) |-> !o_de && !o_hsync && !o_vsync)
        else begin
            $error("timing outputs not cleared by reset");
            sva_errors++;
        end

    a_de_low_after_reset: assert property (@(posedge clk) disable iff (i_rst)
        (since_rst < 2'(WB_LATENCY)) |-> !o_de)
        else begin
            $error("o_de went high within 3 cycles of reset release");
            sva_errors++;
        end

endmodule : white_balance_sva

bind white_balance white_balance_sva #(.H_ACT(H_ACT), .V_ACT(V_ACT)) i_sva (
    .clk(clk), .i_rst(i_rst), .i_vsync(i_vsync), .i_hsync(i_hsync), .i_de(i_de),
    .i_x(i_x), .i_y(i_y), .o_vsync(o_vsync), .o_hsync(o_hsync), .o_de(o_de),
    .o_x(o_x), .o_y(o_y)
);

//--- source/white_balance.sv
`timescale 1ns/1ps

module white_balance import wb_pkg::*; #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_vsync,
    input  logic                     i_hsync,
    input  logic                     i_de,
    input  logic [PIX_W-1:0]         i_r,
    input  logic [PIX_W-1:0]         i_g,
    input  logic [PIX_W-1:0]         i_b,
    input  logic [$clog2(H_ACT)-1:0] i_x,
    input  logic [$clog2(V_ACT)-1:0] i_y,
    output logic                     o_vsync,
    output logic                     o_hsync,
    output logic                     o_de,
    output logic [PIX_W-1:0]         o_r,
    output logic [PIX_W-1:0]         o_g,
    output logic [PIX_W-1:0]         o_b,
    output logic [$clog2(H_ACT)-1:0] o_x,
    output logic [$clog2(V_ACT)-1:0] o_y
);

    localparam int X_W = $clog2(H_ACT);
    localparam int Y_W = $clog2(V_ACT);

    logic [PIX_W-1:0]   avg_r;
    logic [PIX_W-1:0]   avg_g;
    logic [PIX_W-1:0]   avg_b;
    logic [PIX_W-1:0]   k;
    logic [RECIP_W-1:0] recip_r;
    logic [RECIP_W-1:0] recip_g;
    logic [RECIP_W-1:0] recip_b;
    sync_t              sync_in;
    sync_t              sync_out;
    coord_t             coord_in;
    coord_t             coord_out;

    frame_stats #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) i_frame_stats (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_vsync(i_vsync),
        .i_de   (i_de),
        .i_r    (i_r),
        .i_g    (i_g),
        .i_b    (i_b),
        .o_avg_r(avg_r),
        .o_avg_g(avg_g),
        .o_avg_b(avg_b),
        .o_k    (k)
    );

    recip_lut i_recip_r (.i_avg(avg_r), .o_recip(recip_r));
    recip_lut i_recip_g (.i_avg(avg_g), .o_recip(recip_g));
    recip_lut i_recip_b (.i_avg(avg_b), .o_recip(recip_b));

    channel_gain i_gain_r (
        .clk(clk), .i_rst(i_rst), .i_pix(i_r), .i_k(k), .i_recip(recip_r), .o_pix(o_r)
    );
    channel_gain i_gain_g (
        .clk(clk), .i_rst(i_rst), .i_pix(i_g), .i_k(k), .i_recip(recip_g), .o_pix(o_g)
    );
    channel_gain i_gain_b (
        .clk(clk), .i_rst(i_rst), .i_pix(i_b), .i_k(k), .i_recip(recip_b), .o_pix(o_b)
    );

    assign sync_in.vsync = i_vsync;
    assign sync_in.hsync = i_hsync;
    assign sync_in.de    = i_de;
    assign coord_in.x    = COORD_W'(i_x); // zero-extended into the wider field
    assign coord_in.y    = COORD_W'(i_y);

    // timing and coordinates follow the gain pipeline
    sync_delay #(.T(sync_t), .DEPTH(WB_LATENCY)) i_sync_delay (
        .clk(clk), .i_rst(i_rst), .i_data(sync_in), .o_data(sync_out)
    );
    sync_delay #(.T(coord_t), .DEPTH(WB_LATENCY)) i_coord_delay (
        .clk(clk), .i_rst(i_rst), .i_data(coord_in), .o_data(coord_out)
    );

    assign o_vsync = sync_out.vsync;
    assign o_hsync = sync_out.hsync;
    assign o_de    = sync_out.de;
    assign o_x     = coord_out.x[X_W-1:0];
    assign o_y     = coord_out.y[Y_W-1:0];

endmodule : white_balance

//--- source/sync_delay.sv
`timescale 1ns/1ps

module sync_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 3
) (
    input  logic clk,
    input  logic i_rst,
    input  T     i_data,
    output T     o_data
);

    T stages [DEPTH];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            stages <= '{default: '0};
        end else begin
            stages[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign o_data = stages[DEPTH-1];

endmodule : sync_delay

//--- source/channel_gain.sv
`timescale 1ns/1ps

module channel_gain import wb_pkg::*; (
    input  logic               clk,
    input  logic               i_rst,
    input  logic [PIX_W-1:0]   i_pix,
    input  logic [PIX_W-1:0]   i_k,
    input  logic [RECIP_W-1:0] i_recip,
    output logic [PIX_W-1:0]   o_pix
);

    localparam int PROD1_W = 2 * PIX_W;
    localparam int PROD2_W = PROD1_W + RECIP_W;
    localparam int UPPER_W = PROD2_W - RECIP_SHIFT;
    localparam logic [UPPER_W-1:0] PIX_MAX = UPPER_W'({PIX_W{1'b1}});

    logic [PROD1_W-1:0] prod1;
    logic [PROD2_W-1:0] prod2;
    logic [UPPER_W-1:0] upper;

    assign upper = prod2[PROD2_W-1:RECIP_SHIFT]; // drop the fraction bits

    // pixel * k
    always_ff @(posedge clk) begin
        if (i_rst) begin
            prod1 <= '0;
        end else begin
            prod1 <= PROD1_W'(i_pix) * PROD1_W'(i_k);
        end
    end

    // (pixel * k) * 2^32 / avg
    always_ff @(posedge clk) begin
        if (i_rst) begin
            prod2 <= '0;
        end else begin
            prod2 <= PROD2_W'(prod1) * PROD2_W'(i_recip);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pix <= '0;
        end else if (upper >= PIX_MAX) begin
            o_pix <= {PIX_W{1'b1}}; // clamp at 255
        end else begin
            o_pix <= upper[PIX_W-1:0];
        end
    end

endmodule : channel_gain

//--- source/recip_lut.sv
`timescale 1ns/1ps

module recip_lut import wb_pkg::*; (
    input  logic [PIX_W-1:0]   i_avg,
    output logic [RECIP_W-1:0] o_recip
);

    localparam int ENTRIES = 2 ** PIX_W;

    typedef logic [ENTRIES-1:0][RECIP_W-1:0] recip_table_t;

    function automatic recip_table_t build_table();
        recip_table_t tbl;
        for (int i = 0; i < ENTRIES; i++) begin
            tbl[i] = recip_of(PIX_W'(i));
        end
        return tbl;
    endfunction

    localparam recip_table_t RECIP_TABLE = build_table();

    assign o_recip = RECIP_TABLE[i_avg]; // pure lookup, no clock

endmodule : recip_lut

//--- source/frame_stats.sv
`timescale 1ns/1ps

module frame_stats import wb_pkg::*; #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_vsync,
    input  logic             i_de,
    input  logic [PIX_W-1:0] i_r,
    input  logic [PIX_W-1:0] i_g,
    input  logic [PIX_W-1:0] i_b,
    output logic [PIX_W-1:0] o_avg_r,
    output logic [PIX_W-1:0] o_avg_g,
    output logic [PIX_W-1:0] o_avg_b,
    output logic [PIX_W-1:0] o_k
);

    localparam int FRAME_TOTAL = H_ACT * V_ACT;
    localparam int TRIM_BITS   = $clog2(FRAME_TOTAL);
    localparam int SUM_W       = TRIM_BITS + PIX_W; // holds a whole frame of 255s

    logic             vsync_d;
    logic             vsync_rise;
    logic [SUM_W-1:0] sum_r;
    logic [SUM_W-1:0] sum_g;
    logic [SUM_W-1:0] sum_b;
    logic [PIX_W+1:0] avg_total;

    assign vsync_rise = i_vsync && !vsync_d;
    assign avg_total  = (PIX_W + 2)'(o_avg_r) + (PIX_W + 2)'(o_avg_g) + (PIX_W + 2)'(o_avg_b);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            vsync_d <= 1'b0;
            sum_r   <= '0;
            sum_g   <= '0;
            sum_b   <= '0;
            o_avg_r <= '0;
            o_avg_g <= '0;
            o_avg_b <= '0;
            o_k     <= '0;
        end else begin
            vsync_d <= i_vsync;
            if (vsync_rise) begin
                o_avg_r <= sum_r[SUM_W-1:TRIM_BITS]; // truncating average
                o_avg_g <= sum_g[SUM_W-1:TRIM_BITS];
                o_avg_b <= sum_b[SUM_W-1:TRIM_BITS];
                sum_r   <= '0;
                sum_g   <= '0;
                sum_b   <= '0;
            end else if (i_de) begin
                sum_r <= sum_r + SUM_W'(i_r);
                sum_g <= sum_g + SUM_W'(i_g);
                sum_b <= sum_b + SUM_W'(i_b);
            end
            o_k <= PIX_W'(avg_total / 3); // gray target, lags averages by one cycle
        end
    end

endmodule : frame_stats

//--- source/wb_pkg.sv
package wb_pkg;

    localparam int PIX_W       = 8;  // one colour sample
    localparam int RECIP_W     = 32; // reciprocal width, value is 2^32 / avg
    localparam int RECIP_SHIFT = 32; // fraction bits dropped after the gain product
    localparam int WB_LATENCY  = 3;  // pixel in to pixel out, in cycles
    localparam int COORD_W     = 16; // coordinate field width in coord_t

    typedef struct packed {
        logic vsync;
        logic hsync;
        logic de;
    } sync_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } coord_t;

    // floor(2^32 / avg), saturated to all ones when the quotient would not fit
    function automatic logic [RECIP_W-1:0] recip_of(input logic [PIX_W-1:0] avg);
        logic [RECIP_W:0] num;
        logic [RECIP_W:0] den;
        logic [RECIP_W:0] quo;
        num = {1'b1, {RECIP_W{1'b0}}};
        den = (RECIP_W + 1)'(avg);
        if (avg < PIX_W'(2)) begin
            return '1; // avg 0 or 1
        end
        quo = num / den;
        return quo[RECIP_W-1:0];
    endfunction

endpackage : wb_pkg
